// File: verilog/rnn_num_pkg.sv
`default_nettype none

// Fixed point formats of the cell datapath
package rnn_num_pkg;

    localparam int WEIGHT_W = 16;
    localparam int STATE_W  = 32;
    localparam int PROD_W   = WEIGHT_W + STATE_W;

    // Weights are Q4.12
    localparam int WEIGHT_FRAC = 12;

    typedef logic signed [WEIGHT_W-1:0] weight_t;

    // Hidden values, input and output are Q16.16
    typedef logic signed [STATE_W-1:0] state_t;

    // Exact product before scaling
    typedef logic signed [PROD_W-1:0] prod_t;

endpackage

`default_nettype wire

// File: verilog/rnn_map_pkg.sv
`default_nettype none

// Layer sizes, APB register map and weight memory layout
package rnn_map_pkg;

    localparam int HIDDEN_SIZE = 4;

    // Weight words by offset, h2h is row-major by source unit
    localparam int W_I2H_BASE = 0;
    localparam int W_H2H_BASE = W_I2H_BASE + HIDDEN_SIZE;
    localparam int W_H2O_BASE = W_H2H_BASE + HIDDEN_SIZE * HIDDEN_SIZE;
    localparam int W_DEPTH    = W_H2O_BASE + HIDDEN_SIZE;

    // Two banks of hidden values
    localparam int S_DEPTH = 2 * HIDDEN_SIZE;

    localparam int W_IDX_W = $clog2(W_DEPTH);
    localparam int S_IDX_W = $clog2(S_DEPTH);
    // Term counter runs up to HIDDEN_SIZE inclusive
    localparam int UNIT_W  = $clog2(HIDDEN_SIZE + 1);

    typedef logic [W_IDX_W-1:0] w_idx_t;
    typedef logic [S_IDX_W-1:0] s_idx_t;
    typedef logic [UNIT_W-1:0]  unit_t;

    localparam int ADDR_W     = 12;
    localparam int APB_DATA_W = 32;

    localparam logic [ADDR_W-1:0] REG_CTRL     = 12'h000;
    localparam logic [ADDR_W-1:0] REG_STATUS   = 12'h004;
    localparam logic [ADDR_W-1:0] REG_X        = 12'h008;
    localparam logic [ADDR_W-1:0] REG_Y        = 12'h00C;
    localparam logic [ADDR_W-1:0] REG_HID_BASE = 12'h100;
    localparam logic [ADDR_W-1:0] REG_WGT_BASE = 12'h400;

    // One word per entry
    localparam logic [ADDR_W-1:0] REG_HID_END = REG_HID_BASE + ADDR_W'(4 * HIDDEN_SIZE);
    localparam logic [ADDR_W-1:0] REG_WGT_END = REG_WGT_BASE + ADDR_W'(4 * W_DEPTH);

endpackage

`default_nettype wire

// File: verilog/rnn_regfile.sv
`default_nettype none

module rnn_regfile #(
    parameter type T     = logic [31:0],
    parameter int  DEPTH = 8
) (
    input  logic                     i_clk,
    input  logic                     i_rst_n,
    input  logic                     i_we,
    input  logic [$clog2(DEPTH)-1:0] i_waddr,
    input  T                         i_wdata,
    input  logic [$clog2(DEPTH)-1:0] i_raddr,
    output T                         o_rdata
);

    T mem [DEPTH];

    always_ff @(posedge i_clk) begin
        if (i_we) begin
            mem[i_waddr] <= i_wdata;
        end
    end

    // Read is combinational, new data visible after the write edge
    assign o_rdata = mem[i_raddr];

    a_waddr_in_range: assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        i_we |-> (int'(i_waddr) < DEPTH)
    );

endmodule

`default_nettype wire

// File: verilog/rnn_mac.sv
`default_nettype none

module rnn_mac (
    input  logic                i_clk,
    input  logic                i_rst_n,
    input  logic                i_clear,
    input  logic                i_acc,
    input  rnn_num_pkg::weight_t i_weight,
    input  rnn_num_pkg::state_t  i_operand,
    output rnn_num_pkg::state_t  o_sum
);

    rnn_num_pkg::prod_t  prod;
    rnn_num_pkg::prod_t  prod_scaled;
    rnn_num_pkg::state_t term;
    rnn_num_pkg::state_t sum_q;

    // Exact signed product, both operands sign extended to the product width
    assign prod = i_weight * i_operand;

    // Back to the state format, then keep the low word
    assign prod_scaled = prod >>> rnn_num_pkg::WEIGHT_FRAC;
    assign term        = rnn_num_pkg::state_t'(prod_scaled);

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            sum_q <= '0;
        end else if (i_acc) begin
            if (i_clear) begin
                sum_q <= term;
            end else begin
                // wraps at 32 bits
                sum_q <= sum_q + term;
            end
        end
    end

    assign o_sum = sum_q;

    a_clear_with_acc: assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        i_clear |-> i_acc
    );

endmodule

`default_nettype wire

// File: verilog/rnn_ctrl.sv
`default_nettype none

module rnn_ctrl (
    input  logic                                 i_clk,
    input  logic                                 i_rst_n,
    // APB slave
    input  logic                                 i_psel,
    input  logic                                 i_penable,
    input  logic                                 i_pwrite,
    input  logic [rnn_map_pkg::ADDR_W-1:0]       i_paddr,
    input  logic [rnn_map_pkg::APB_DATA_W-1:0]   i_pwdata,
    output logic [rnn_map_pkg::APB_DATA_W-1:0]   o_prdata,
    output logic                                 o_pready,
    output logic                                 o_pslverr,
    // Weight file
    output logic                                 o_w_we,
    output rnn_map_pkg::w_idx_t                  o_w_waddr,
    output rnn_num_pkg::weight_t                 o_w_wdata,
    output rnn_map_pkg::w_idx_t                  o_w_raddr,
    input  rnn_num_pkg::weight_t                 i_w_rdata,
    // State file
    output logic                                 o_s_we,
    output rnn_map_pkg::s_idx_t                  o_s_waddr,
    output rnn_num_pkg::state_t                  o_s_wdata,
    output rnn_map_pkg::s_idx_t                  o_s_raddr,
    input  rnn_num_pkg::state_t                  i_s_rdata,
    // Accumulator
    output logic                                 o_mac_clear,
    output logic                                 o_mac_acc,
    output rnn_num_pkg::state_t                  o_mac_operand,
    input  rnn_num_pkg::state_t                  i_mac_sum
);

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_HACC,
        ST_WB,
        ST_OACC,
        ST_FIN
    } seq_state_e;

    // Bank 1 sits above bank 0 in the state file
    function automatic rnn_map_pkg::s_idx_t s_addr(input logic bank,
                                                   input rnn_map_pkg::unit_t idx);
        rnn_map_pkg::s_idx_t base;
        base = bank ? rnn_map_pkg::s_idx_t'(rnn_map_pkg::HIDDEN_SIZE) : '0;
        return base + rnn_map_pkg::s_idx_t'(idx);
    endfunction

    seq_state_e              state_q;
    rnn_map_pkg::unit_t      unit_q;
    rnn_map_pkg::unit_t      term_q;
    logic                    bank_q;
    logic                    busy;
    rnn_num_pkg::state_t     x_q;
    rnn_num_pkg::state_t     y_q;
    logic                    pslverr_q;

    logic                    setup;
    logic                    access;
    logic                    wr_ok;
    logic                    start;
    logic                    hit_ctrl;
    logic                    hit_status;
    logic                    hit_x;
    logic                    hit_y;
    logic                    hit_hid;
    logic                    hit_wgt;
    logic                    mapped;
    logic                    ro_write;
    logic                    busy_ok;
    logic                    req_err;
    logic [rnn_map_pkg::ADDR_W-1:0] hid_off;
    logic [rnn_map_pkg::ADDR_W-1:0] wgt_off;
    rnn_map_pkg::unit_t      hid_idx;
    rnn_map_pkg::w_idx_t     wgt_idx;

    // Copy of the state file, serves hidden reads while the sequencer holds the read port
    rnn_num_pkg::state_t     hid_mirror [rnn_map_pkg::S_DEPTH];

    assign busy = (state_q != ST_IDLE);

    // Address decode
    assign hit_ctrl   = (i_paddr == rnn_map_pkg::REG_CTRL);
    assign hit_status = (i_paddr == rnn_map_pkg::REG_STATUS);
    assign hit_x      = (i_paddr == rnn_map_pkg::REG_X);
    assign hit_y      = (i_paddr == rnn_map_pkg::REG_Y);
    assign hit_hid    = (i_paddr >= rnn_map_pkg::REG_HID_BASE) &&
                        (i_paddr <  rnn_map_pkg::REG_HID_END) && (i_paddr[1:0] == 2'b00);
    assign hit_wgt    = (i_paddr >= rnn_map_pkg::REG_WGT_BASE) &&
                        (i_paddr <  rnn_map_pkg::REG_WGT_END) && (i_paddr[1:0] == 2'b00);

    assign hid_off = i_paddr - rnn_map_pkg::REG_HID_BASE;
    assign wgt_off = i_paddr - rnn_map_pkg::REG_WGT_BASE;
    assign hid_idx = hid_off[rnn_map_pkg::UNIT_W+1:2];
    assign wgt_idx = wgt_off[rnn_map_pkg::W_IDX_W+1:2];

    assign mapped   = hit_ctrl | hit_status | hit_x | hit_y | hit_hid | hit_wgt;
    assign ro_write = i_pwrite & (hit_status | hit_y);
    assign busy_ok  = ~i_pwrite & (hit_status | hit_y | hit_hid);
    assign req_err  = ~mapped | ro_write | (busy & ~busy_ok);

    assign setup  = i_psel & ~i_penable;
    assign access = i_psel & i_penable;
    assign wr_ok  = access & i_pwrite & ~pslverr_q;
    assign start  = wr_ok & hit_ctrl & i_pwdata[0];

    // Error decided in setup, presented in the access cycle
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            pslverr_q <= 1'b0;
        end else begin
            pslverr_q <= setup & req_err;
        end
    end

    assign o_pready  = 1'b1;
    assign o_pslverr = pslverr_q;

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            x_q <= '0;
        end else if (wr_ok && hit_x) begin
            x_q <= rnn_num_pkg::state_t'(i_pwdata);
        end
    end

    assign o_w_we    = wr_ok & hit_wgt;
    assign o_w_waddr = wgt_idx;
    assign o_w_wdata = rnn_num_pkg::weight_t'(i_pwdata[rnn_num_pkg::WEIGHT_W-1:0]);

    // APB writes the current bank, write-back fills the other one
    always_comb begin
        if (state_q == ST_WB) begin
            o_s_we    = 1'b1;
            o_s_waddr = s_addr(~bank_q, unit_q);
            o_s_wdata = i_mac_sum;
        end else begin
            o_s_we    = wr_ok & hit_hid;
            o_s_waddr = s_addr(bank_q, hid_idx);
            o_s_wdata = rnn_num_pkg::state_t'(i_pwdata);
        end
    end

    always_ff @(posedge i_clk) begin
        if (o_s_we) begin
            hid_mirror[o_s_waddr] <= o_s_wdata;
        end
    end

    // Read ports and accumulator controls
    always_comb begin
        o_w_raddr     = wgt_idx;
        o_s_raddr     = s_addr(bank_q, hid_idx);
        o_mac_acc     = 1'b0;
        o_mac_clear   = 1'b0;
        o_mac_operand = i_s_rdata;
        case (state_q)
            ST_HACC: begin
                o_mac_acc   = 1'b1;
                o_mac_clear = (term_q == '0);
                if (term_q == '0) begin
                    o_w_raddr     = rnn_map_pkg::w_idx_t'(rnn_map_pkg::W_I2H_BASE + int'(unit_q));
                    o_mac_operand = x_q;
                end else begin
                    // Source unit term_q-1 feeds unit unit_q
                    o_w_raddr = rnn_map_pkg::w_idx_t'(rnn_map_pkg::W_H2H_BASE +
                                (int'(term_q) - 1) * rnn_map_pkg::HIDDEN_SIZE + int'(unit_q));
                    o_s_raddr = s_addr(bank_q, term_q - 1'b1);
                end
            end
            ST_OACC: begin
                o_mac_acc   = 1'b1;
                o_mac_clear = (term_q == '0);
                o_w_raddr   = rnn_map_pkg::w_idx_t'(rnn_map_pkg::W_H2O_BASE + int'(term_q));
                o_s_raddr   = s_addr(~bank_q, term_q);
            end
            default: begin
            end
        endcase
    end

    // Step sequencer
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state_q <= ST_IDLE;
            unit_q  <= '0;
            term_q  <= '0;
            bank_q  <= 1'b0;
            y_q     <= '0;
        end else begin
            case (state_q)
                ST_IDLE: begin
                    if (start) begin
                        state_q <= ST_HACC;
                        unit_q  <= '0;
                        term_q  <= '0;
                    end
                end
                ST_HACC: begin
                    if (term_q == rnn_map_pkg::unit_t'(rnn_map_pkg::HIDDEN_SIZE)) begin
                        state_q <= ST_WB;
                    end else begin
                        term_q <= term_q + 1'b1;
                    end
                end
                ST_WB: begin
                    term_q <= '0;
                    if (unit_q == rnn_map_pkg::unit_t'(rnn_map_pkg::HIDDEN_SIZE - 1)) begin
                        unit_q  <= '0;
                        state_q <= ST_OACC;
                    end else begin
                        unit_q  <= unit_q + 1'b1;
                        state_q <= ST_HACC;
                    end
                end
                ST_OACC: begin
                    if (term_q == rnn_map_pkg::unit_t'(rnn_map_pkg::HIDDEN_SIZE - 1)) begin
                        state_q <= ST_FIN;
                    end else begin
                        term_q <= term_q + 1'b1;
                    end
                end
                ST_FIN: begin
                    y_q     <= i_mac_sum;
                    bank_q  <= ~bank_q;
                    state_q <= ST_IDLE;
                end
                default: begin
                    state_q <= ST_IDLE;
                end
            endcase
        end
    end

    // Read data for the access cycle
    always_comb begin
        o_prdata = '0;
        if (!i_pwrite && !pslverr_q) begin
            if (hit_status) begin
                o_prdata[0] = busy;
            end else if (hit_x) begin
                o_prdata = x_q;
            end else if (hit_y) begin
                o_prdata = y_q;
            end else if (hit_hid) begin
                o_prdata = busy ? hid_mirror[s_addr(bank_q, hid_idx)] : i_s_rdata;
            end else if (hit_wgt) begin
                o_prdata[rnn_num_pkg::WEIGHT_W-1:0] = i_w_rdata;
            end
        end
    end

    // The old bank stays intact for the whole step
    a_wb_other_bank: assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        (busy && o_s_we) |->
            ((o_s_waddr >= rnn_map_pkg::s_idx_t'(rnn_map_pkg::HIDDEN_SIZE)) == !bank_q)
    );

endmodule

`default_nettype wire

// File: verilog/rnn_cell_top.sv
`default_nettype none

module rnn_cell_top (
    input  logic                               i_clk,
    input  logic                               i_rst_n,
    input  logic                               i_psel,
    input  logic                               i_penable,
    input  logic                               i_pwrite,
    input  logic [rnn_map_pkg::ADDR_W-1:0]     i_paddr,
    input  logic [rnn_map_pkg::APB_DATA_W-1:0] i_pwdata,
    output logic [rnn_map_pkg::APB_DATA_W-1:0] o_prdata,
    output logic                               o_pready,
    output logic                               o_pslverr
);

    logic                 w_we;
    rnn_map_pkg::w_idx_t  w_waddr;
    rnn_num_pkg::weight_t w_wdata;
    rnn_map_pkg::w_idx_t  w_raddr;
    rnn_num_pkg::weight_t w_rdata;

    logic                 s_we;
    rnn_map_pkg::s_idx_t  s_waddr;
    rnn_num_pkg::state_t  s_wdata;
    rnn_map_pkg::s_idx_t  s_raddr;
    rnn_num_pkg::state_t  s_rdata;

    logic                 mac_clear;
    logic                 mac_acc;
    rnn_num_pkg::state_t  mac_operand;
    rnn_num_pkg::state_t  mac_sum;

    rnn_ctrl u_ctrl (
        .i_clk         (i_clk),
        .i_rst_n       (i_rst_n),
        .i_psel        (i_psel),
        .i_penable     (i_penable),
        .i_pwrite      (i_pwrite),
        .i_paddr       (i_paddr),
        .i_pwdata      (i_pwdata),
        .o_prdata      (o_prdata),
        .o_pready      (o_pready),
        .o_pslverr     (o_pslverr),
        .o_w_we        (w_we),
        .o_w_waddr     (w_waddr),
        .o_w_wdata     (w_wdata),
        .o_w_raddr     (w_raddr),
        .i_w_rdata     (w_rdata),
        .o_s_we        (s_we),
        .o_s_waddr     (s_waddr),
        .o_s_wdata     (s_wdata),
        .o_s_raddr     (s_raddr),
        .i_s_rdata     (s_rdata),
        .o_mac_clear   (mac_clear),
        .o_mac_acc     (mac_acc),
        .o_mac_operand (mac_operand),
        .i_mac_sum     (mac_sum)
    );

    rnn_regfile #(
        .T     (rnn_num_pkg::weight_t),
        .DEPTH (rnn_map_pkg::W_DEPTH)
    ) u_weights (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_we    (w_we),
        .i_waddr (w_waddr),
        .i_wdata (w_wdata),
        .i_raddr (w_raddr),
        .o_rdata (w_rdata)
    );

    // Two banks of hidden values
    rnn_regfile #(
        .T     (rnn_num_pkg::state_t),
        .DEPTH (rnn_map_pkg::S_DEPTH)
    ) u_states (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_we    (s_we),
        .i_waddr (s_waddr),
        .i_wdata (s_wdata),
        .i_raddr (s_raddr),
        .o_rdata (s_rdata)
    );

    rnn_mac u_mac (
        .i_clk     (i_clk),
        .i_rst_n   (i_rst_n),
        .i_clear   (mac_clear),
        .i_acc     (mac_acc),
        .i_weight  (w_rdata),
        .i_operand (mac_operand),
        .o_sum     (mac_sum)
    );

endmodule

`default_nettype wire

// File: dv/tb_clkgen.sv
`default_nettype none

module tb_clkgen (
    output logic o_clk,
    output logic o_rst_n
);

    initial begin
        o_clk = 1'b0;
        forever begin
            #2 o_clk = ~o_clk;
        end
    end

    // Reset held for 5 cycles
    initial begin
        o_rst_n = 1'b0;
        repeat (5) @(posedge o_clk);
        #1 o_rst_n = 1'b1;
    end

endmodule

`default_nettype wire

// File: dv/rnn_tb.sv
`default_nettype none

module rnn_tb;

    localparam int HS          = rnn_map_pkg::HIDDEN_SIZE;
    localparam int WD          = rnn_map_pkg::W_DEPTH;
    localparam int STEP_CYCLES = HS * (HS + 2) + HS + 1;
    localparam int MAX_REC     = 64;

    logic        clk;
    logic        rst_n;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [11:0] paddr;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;

    string       rec_kind [MAX_REC];
    string       rec_name [MAX_REC];
    logic [31:0] rec_val  [MAX_REC][32];
    int          n_rec;

    // Reference model of the cell
    rnn_num_pkg::weight_t m_w [WD];
    rnn_num_pkg::state_t  m_h [HS];
    rnn_num_pkg::state_t  m_x;
    rnn_num_pkg::state_t  m_y;

    int          errors;
    int          tests;
    int          passed;
    bit          test_ok;
    bit          wd_armed;
    longint      wd_limit;
    logic [31:0] lcg_state;

    tb_clkgen clk_i (
        .o_clk   (clk),
        .o_rst_n (rst_n)
    );

    rnn_cell_top dut_i (
        .i_clk     (clk),
        .i_rst_n   (rst_n),
        .i_psel    (psel),
        .i_penable (penable),
        .i_pwrite  (pwrite),
        .i_paddr   (paddr),
        .i_pwdata  (pwdata),
        .o_prdata  (prdata),
        .o_pready  (pready),
        .o_pslverr (pslverr)
    );

    function logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    // Exact product shifted right arithmetically and cut to 32 bits
    function automatic rnn_num_pkg::state_t scale_mul(input rnn_num_pkg::weight_t w,
                                                      input rnn_num_pkg::state_t s);
        rnn_num_pkg::prod_t p;
        p = rnn_num_pkg::prod_t'(w) * rnn_num_pkg::prod_t'(s);
        return rnn_num_pkg::state_t'(p >>> rnn_num_pkg::WEIGHT_FRAC);
    endfunction

    task automatic model_step();
        rnn_num_pkg::state_t nh [HS];
        rnn_num_pkg::state_t acc;
        for (int u = 0; u < HS; u++) begin
            acc = scale_mul(m_w[rnn_map_pkg::W_I2H_BASE + u], m_x);
            for (int s = 0; s < HS; s++) begin
                acc = acc + scale_mul(m_w[rnn_map_pkg::W_H2H_BASE + s * HS + u], m_h[s]);
            end
            nh[u] = acc;
        end
        m_y = '0;
        for (int u = 0; u < HS; u++) begin
            m_h[u] = nh[u];
            m_y    = m_y + scale_mul(m_w[rnn_map_pkg::W_H2O_BASE + u], nh[u]);
        end
    endtask

    function automatic int value_count(input string kw);
        if (kw == "W") return WD;
        if (kw == "H") return HS;
        if (kw == "S") return HS + 2;
        if (kw == "E") return 4;
        return -1;
    endfunction

    task automatic read_cases();
        int          fd;
        int          code;
        int          cnt;
        string       kw;
        string       nm;
        string       line;
        logic [31:0] v;
        fd = $fopen("dv/rnn_cases.txt", "r");
        if (fd == 0) begin
            $display("Cannot open dv/rnn_cases.txt");
            errors++;
            return;
        end
        while (!$feof(fd)) begin
            code = $fscanf(fd, "%s", kw);
            if (code != 1) break;
            if (kw[0] == 8'h23) begin
                code = $fgets(line, fd);
                continue;
            end
            cnt  = value_count(kw);
            code = $fscanf(fd, "%s", nm);
            if (cnt < 0 || n_rec >= MAX_REC) begin
                $display("Bad record %s %s in case file", kw, nm);
                errors++;
                break;
            end
            rec_kind[n_rec] = kw;
            rec_name[n_rec] = nm;
            for (int i = 0; i < cnt; i++) begin
                code = $fscanf(fd, "%h", v);
                rec_val[n_rec][i] = v;
            end
            n_rec++;
        end
        $fclose(fd);
    endtask

    task automatic apb_xfer(input logic wr, input logic [11:0] addr, input logic [31:0] data,
                            output logic [31:0] rdata, output logic err);
        @(posedge clk);
        #1;
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = wr;
        paddr   = addr;
        pwdata  = data;
        @(posedge clk);
        #1 penable = 1'b1;
        #2;
        rdata = prdata;
        err   = pslverr;
        if (pready !== 1'b1) begin
            $display("APB access to %h stalled with pready low in the access cycle", addr);
            errors++;
            test_ok = 1'b0;
        end
        @(posedge clk);
        #1;
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic check_state(input string name, input rnn_num_pkg::state_t exp,
                               input rnn_num_pkg::state_t act);
        if (exp !== act) begin
            $display("ERR %s expected %h actual %h", name, exp, act);
            errors++;
            test_ok = 1'b0;
        end
    endtask

    task automatic check_weight(input string name, input rnn_num_pkg::weight_t exp,
                                input rnn_num_pkg::weight_t act);
        if (exp !== act) begin
            $display("ERR %s expected %h actual %h", name, exp, act);
            errors++;
            test_ok = 1'b0;
        end
    endtask

    task automatic check_resp(input string name, input logic exp, input logic act);
        if (exp !== act) begin
            $display("ERR %s expected pslverr %b actual %b", name, exp, act);
            errors++;
            test_ok = 1'b0;
        end
    endtask

    task automatic write_ok(input string name, input logic [11:0] addr, input logic [31:0] d);
        logic [31:0] rd;
        logic        err;
        apb_xfer(1'b1, addr, d, rd, err);
        check_resp(name, 1'b0, err);
    endtask

    task automatic wait_idle(input string name);
        logic [31:0] rd;
        logic        err;
        rd = 32'h1;
        while (rd[0]) begin
            apb_xfer(1'b0, rnn_map_pkg::REG_STATUS, '0, rd, err);
            check_resp(name, 1'b0, err);
        end
    endtask

    task automatic run_step(input string name, input rnn_num_pkg::state_t x);
        write_ok(name, rnn_map_pkg::REG_X, x);
        write_ok(name, rnn_map_pkg::REG_CTRL, 32'h1);
        wait_idle(name);
    endtask

    task automatic check_results(input string name, input rnn_num_pkg::state_t exp_h [HS],
                                 input rnn_num_pkg::state_t exp_y);
        logic [31:0] rd;
        logic        err;
        for (int i = 0; i < HS; i++) begin
            apb_xfer(1'b0, rnn_map_pkg::REG_HID_BASE + 12'(4 * i), '0, rd, err);
            check_resp(name, 1'b0, err);
            check_state(name, exp_h[i], rd);
        end
        apb_xfer(1'b0, rnn_map_pkg::REG_Y, '0, rd, err);
        check_resp(name, 1'b0, err);
        check_state(name, exp_y, rd);
    endtask

    task automatic load_weights(input string name);
        logic [31:0] rd;
        logic        err;
        for (int i = 0; i < WD; i++) begin
            write_ok(name, rnn_map_pkg::REG_WGT_BASE + 12'(4 * i), 32'(m_w[i]));
        end
        for (int i = 0; i < WD; i++) begin
            apb_xfer(1'b0, rnn_map_pkg::REG_WGT_BASE + 12'(4 * i), '0, rd, err);
            check_resp(name, 1'b0, err);
            check_weight(name, m_w[i], rd[15:0]);
            check_weight(name, '0, rd[31:16]);
        end
    endtask

    task automatic load_hidden(input string name);
        logic [31:0] rd;
        logic        err;
        for (int i = 0; i < HS; i++) begin
            write_ok(name, rnn_map_pkg::REG_HID_BASE + 12'(4 * i), m_h[i]);
        end
        for (int i = 0; i < HS; i++) begin
            apb_xfer(1'b0, rnn_map_pkg::REG_HID_BASE + 12'(4 * i), '0, rd, err);
            check_resp(name, 1'b0, err);
            check_state(name, m_h[i], rd);
        end
    endtask

    task automatic run_record(input int r);
        rnn_num_pkg::state_t exp_h [HS];
        logic [31:0]         rd;
        logic                err;
        string               nm;
        nm = rec_name[r];
        case (rec_kind[r])
            "W": begin
                for (int i = 0; i < WD; i++) m_w[i] = rec_val[r][i][15:0];
                load_weights(nm);
            end
            "H": begin
                for (int i = 0; i < HS; i++) m_h[i] = rec_val[r][i];
                load_hidden(nm);
            end
            "S": begin
                m_x = rec_val[r][0];
                model_step();
                for (int i = 0; i < HS; i++) begin
                    exp_h[i] = rec_val[r][1 + i];
                    if (exp_h[i] !== m_h[i]) begin
                        $display("Data error in %s: file gives %h for hidden %0d, model gives %h",
                                 nm, exp_h[i], i, m_h[i]);
                        errors++;
                        test_ok = 1'b0;
                    end
                end
                if (rec_val[r][HS + 1] !== m_y) begin
                    $display("Data error in %s: file gives y %h, model gives %h",
                             nm, rec_val[r][HS + 1], m_y);
                    errors++;
                    test_ok = 1'b0;
                end
                run_step(nm, m_x);
                check_results(nm, exp_h, rec_val[r][HS + 1]);
            end
            default: begin
                // Busy case starts a real step first so the refused access lands mid-step
                if (rec_val[r][0][0]) begin
                    write_ok(nm, rnn_map_pkg::REG_CTRL, 32'h1);
                    model_step();
                end
                apb_xfer(rec_val[r][1][0], rec_val[r][2][11:0], rec_val[r][3], rd, err);
                check_resp(nm, 1'b1, err);
                if (rec_val[r][0][0]) begin
                    wait_idle(nm);
                    check_results(nm, m_h, m_y);
                end
            end
        endcase
    endtask

    task automatic run_random();
        for (int i = 0; i < WD; i++) m_w[i] = rnn_num_pkg::weight_t'(lcg_next() >> 16);
        for (int i = 0; i < HS; i++) m_h[i] = lcg_next();
        m_x = lcg_next();
        load_weights("random");
        load_hidden("random");
        model_step();
        run_step("random", m_x);
        check_results("random", m_h, m_y);
    endtask

    task automatic finish_test(input string name);
        tests++;
        if (test_ok) passed++;
        $display("%-14s %s", name, test_ok ? "ok" : "FAILED");
    endtask

    // Watchdog allows each record a step plus a full weight load
    initial begin
        wait (wd_armed);
        #(wd_limit);
        $display("Timeout after %0d time units, DUT did not finish", wd_limit);
        $display("Simulation failed");
        $finish;
    end

    initial begin
        psel      = 1'b0;
        penable   = 1'b0;
        pwrite    = 1'b0;
        paddr     = '0;
        pwdata    = '0;
        errors    = 0;
        tests     = 0;
        passed    = 0;
        n_rec     = 0;
        wd_armed  = 1'b0;
        lcg_state = 32'd53196;
        read_cases();
        wd_limit = longint'(n_rec + 1) * (STEP_CYCLES + 40 + 6 * WD) * 4;
        wd_armed = 1'b1;
        wait (rst_n);
        @(posedge clk);
        for (int r = 0; r < n_rec; r++) begin
            test_ok = 1'b1;
            run_record(r);
            finish_test(rec_name[r]);
        end
        test_ok = 1'b1;
        run_random();
        finish_test("random");
        $display("%0d tests, %0d passed, %0d errors", tests, passed, errors);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: sim.f
verilog/rnn_num_pkg.sv
verilog/rnn_map_pkg.sv
verilog/rnn_regfile.sv
verilog/rnn_mac.sv
verilog/rnn_ctrl.sv
verilog/rnn_cell_top.sv
dv/tb_clkgen.sv
dv/rnn_tb.sv

// File: Makefile
.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -Wno-fatal -f sim.f --top-module rnn_tb -Mdir obj_dir

run: compile
	./obj_dir/Vrnn_tb | tee /dev/stderr | grep -q "^Simulation passed$$"

clean:
	rm -rf obj_dir

// File: dv/rnn_cases.txt
# W name: i2h[4] h2h[16] (src*4+dst) h2o[4], Q4.12 hex
# H name: hidden[4]  S name: x new_hidden[4] y  E name: busy write addr data
W w_i2h 1000 2000 F000 0800 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 1000 1000 1000 1000
H h_zero 0 0 0 0
S s_i2h 00010000 00010000 00020000 FFFF0000 00008000 00028000
# Identity feedback, y picks unit 0
W w_chain 1000 1000 1000 1000 1000 0 0 0 0 1000 0 0 0 0 1000 0 0 0 0 1000 1000 0 0 0
H h_chain 00010000 00020000 00030000 00040000
S s_chain1 00010000 00020000 00030000 00040000 00050000 00020000
S s_chain2 00020000 00040000 00050000 00060000 00070000 00040000
E e_busy_start 1 1 000 00000001
E e_busy_wgt 1 1 400 00000000
E e_busy_hid 1 1 100 00000000
S s_after_busy 00010000 000B0000 000C0000 000D0000 000E0000 000B0000
E e_unmapped 0 0 800 00000000
E e_write_y 0 1 00C 00000005
# Large operands, sums wrap at 32 bits
W w_wrap 7FFF 0 0 0 7FFF 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 1000 0 0 0
H h_wrap 7FFFFFFF 0 0 0
S s_wrap 7FFFFFFF FFEFFFF0 00000000 00000000 00000000 FFEFFFF0
